// File: design/rvPkg.sv
/* rvPkg
   widths, ALU operation codes and the records carried between pipeline stages */
package rvPkg;

	// data path and register index widths
	localparam int xLen = 32;
	localparam int regAddrW = 5;

	typedef logic [xLen-1:0] word_t;
	typedef logic [regAddrW-1:0] regAddr_t;

	// ALU operations, passB feeds the immediate straight through for LUI
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluPassB
	} aluOp_t;

	// one request on the shared single-port memory bus
	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic write;
		logic valid;
	} memReq_t;

	// IF/ID contents
	typedef struct packed {
		word_t instr;
		word_t pc;
	} ifIdStage_t;

	// ID/EX contents, control bits first
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic branch;
		logic branchNe;
		logic jump;
		aluOp_t aluOp;
		regAddr_t rs1;
		regAddr_t rs2;
		regAddr_t rd;
		word_t rs1Val;
		word_t rs2Val;
		word_t imm;
		word_t pc;
	} idExStage_t;

	// EX/MEM contents
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		word_t aluOut;
		word_t storeData;
		regAddr_t rd;
	} exMemStage_t;

	// MEM/WB contents
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		word_t aluOut;
		word_t loadData;
		regAddr_t rd;
	} memWbStage_t;

endpackage

// File: design/fetchUnit.sv
`timescale 1ns/1ps
/* fetchUnit
   program counter, next pc select and the instruction read request */
module fetchUnit import rvPkg::*; #(
	parameter word_t resetPc = '0
) (
	input logic clk,
	input logic reset,
	input logic pcEn,
	input logic takeBranch,
	input word_t target,
	input word_t memRdata,
	output memReq_t fetchReq,
	output word_t fetchPc,
	output word_t fetchInstr
);

	word_t pc;
	word_t pcPlus4;
	word_t nextPc;

	assign pcPlus4 = pc + 32'd4;
	// redirect from execute wins over sequential flow
	assign nextPc = takeBranch ? target : pcPlus4;

	// pc latch, enable is active low like the stage latches
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc <= resetPc;
		end else if (!pcEn) begin
			pc <= nextPc;
		end
	end

	// read of the current pc every cycle, the arbiter may refuse it
	always_comb begin
		fetchReq = '0;
		fetchReq.addr = pc;
		fetchReq.valid = 1'b1;
	end

	assign fetchPc = pc;
	// bus read is combinational, so the word is here in the same cycle
	assign fetchInstr = memRdata;

endmodule

// File: design/memArbiter.sv
`timescale 1ns/1ps
/* memArbiter
   fixed priority share of the memory bus, data access ahead of fetch */
module memArbiter import rvPkg::*; (
	input memReq_t fetchReq,
	input memReq_t dataReq,
	output logic fetchGrant,
	output word_t memAddr,
	output word_t memWdata,
	output logic memWe
);

	memReq_t busReq;

	// a load or store in the memory stage takes the bus
	// fetch only gets it on cycles with no data access
	assign fetchGrant = !dataReq.valid;

	// winning request
	assign busReq = dataReq.valid ? dataReq : fetchReq;

	// drive the external bus from the winner
	assign memAddr = busReq.addr;
	assign memWdata = busReq.wdata;
	// write strobe only for a live request
	assign memWe = busReq.valid & busReq.write;

endmodule

// File: design/decodeUnit.sv
`timescale 1ns/1ps
/* decodeUnit
   register file with write-through and the RV32I subset decoder */
module decodeUnit import rvPkg::*; (
	input logic clk,
	input logic reset,
	input ifIdStage_t ifId,
	input logic wbWe,
	input regAddr_t wbRd,
	input word_t wbData,
	output idExStage_t idOut
);

	// major opcodes of the supported subset
	localparam logic [6:0] opReg = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;

	// x0 has no storage
	word_t regs [1:31];
	word_t instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	regAddr_t rs1;
	regAddr_t rs2;
	regAddr_t rd;
	word_t immI;
	word_t immS;
	word_t immB;
	word_t immU;
	word_t immJ;

	assign instr = ifId.instr;
	assign opcode = instr[6:0];
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign funct7 = instr[31:25];

	// immediates, all sign extended from bit 31
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// write port from writeback, writes to x0 are dropped
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWe && wbRd != '0) begin
			regs[wbRd] <= wbData;
		end
	end

	// read port, a same cycle writeback goes straight through
	function automatic word_t readReg(input regAddr_t addr);
		word_t val;
		if (addr == '0) begin
			val = '0;
		end else if (wbWe && addr == wbRd) begin
			val = wbData;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		// unknown encodings leave every control bit low, a no-op
		idOut = '0;
		idOut.aluOp = aluAdd;
		idOut.rs1 = rs1;
		idOut.rs2 = rs2;
		idOut.rd = rd;
		idOut.rs1Val = readReg(rs1);
		idOut.rs2Val = readReg(rs2);
		idOut.pc = ifId.pc;
		case (opcode)
			opReg: begin
				idOut.regWrite = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: idOut.aluOp = aluAdd;
					{7'b0100000, 3'b000}: idOut.aluOp = aluSub;
					{7'b0000000, 3'b111}: idOut.aluOp = aluAnd;
					{7'b0000000, 3'b110}: idOut.aluOp = aluOr;
					{7'b0000000, 3'b100}: idOut.aluOp = aluXor;
					default: idOut.regWrite = 1'b0;
				endcase
			end
			opImm: begin
				// ADDI only
				idOut.regWrite = (funct3 == 3'b000);
				idOut.aluSrc = 1'b1;
				idOut.imm = immI;
			end
			opLui: begin
				idOut.regWrite = 1'b1;
				idOut.aluSrc = 1'b1;
				idOut.aluOp = aluPassB;
				idOut.imm = immU;
			end
			opLoad: begin
				// word loads only
				idOut.regWrite = (funct3 == 3'b010);
				idOut.memToReg = (funct3 == 3'b010);
				idOut.aluSrc = 1'b1;
				idOut.imm = immI;
			end
			opStore: begin
				idOut.memWrite = (funct3 == 3'b010);
				idOut.aluSrc = 1'b1;
				idOut.imm = immS;
			end
			opBranch: begin
				// BEQ is funct3 000, BNE is 001
				idOut.branch = (funct3[2:1] == 2'b00);
				idOut.branchNe = (funct3 == 3'b001);
				idOut.imm = immB;
			end
			opJal: begin
				idOut.regWrite = 1'b1;
				idOut.jump = 1'b1;
				idOut.imm = immJ;
			end
			default: begin
				idOut.imm = '0;
			end
		endcase
	end

endmodule

// File: design/execUnit.sv
`timescale 1ns/1ps
/* execUnit
   operand forwarding, ALU, branch compare and branch or jump target */
module execUnit import rvPkg::*; (
	input idExStage_t idEx,
	input exMemStage_t exMem,
	input memWbStage_t memWb,
	output exMemStage_t exOut,
	output logic takeBranch,
	output word_t target
);

	word_t wbVal;
	word_t opA;
	word_t rs2Fwd;
	word_t opB;
	word_t aluOut;
	logic equal;
	logic condMet;

	// value that writeback is about to store
	assign wbVal = memWb.memToReg ? memWb.loadData : memWb.aluOut;

	// newest producer wins with EX/MEM ahead of MEM/WB and x0 never forwarded
	function automatic word_t fwd(input regAddr_t src, input word_t regVal);
		word_t val;
		if (exMem.regWrite && exMem.rd != '0 && exMem.rd == src) begin
			val = exMem.aluOut;
		end else if (memWb.regWrite && memWb.rd != '0 && memWb.rd == src) begin
			val = wbVal;
		end else begin
			val = regVal;
		end
		return val;
	endfunction

	// re-evaluated whenever a later stage changes
	always_comb begin
		opA = fwd(idEx.rs1, idEx.rs1Val);
		rs2Fwd = fwd(idEx.rs2, idEx.rs2Val);
	end

	assign opB = idEx.aluSrc ? idEx.imm : rs2Fwd;

	always_comb begin
		case (idEx.aluOp)
			aluSub: aluOut = opA - opB;
			aluAnd: aluOut = opA & opB;
			aluOr: aluOut = opA | opB;
			aluXor: aluOut = opA ^ opB;
			aluPassB: aluOut = opB;
			default: aluOut = opA + opB;
		endcase
	end

	// BEQ and BNE compare the two forwarded registers
	assign equal = (opA == rs2Fwd);
	assign condMet = idEx.branchNe ? !equal : equal;
	assign takeBranch = idEx.jump | (idEx.branch & condMet);
	assign target = idEx.pc + idEx.imm;

	always_comb begin
		exOut.regWrite = idEx.regWrite;
		exOut.memToReg = idEx.memToReg;
		exOut.memWrite = idEx.memWrite;
		// JAL links pc+4 instead of the ALU result
		exOut.aluOut = idEx.jump ? idEx.pc + 32'd4 : aluOut;
		exOut.storeData = rs2Fwd;
		exOut.rd = idEx.rd;
	end

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/1ps
/* hazardUnit
   load-use stall, refused-fetch bubble and taken branch flush */
module hazardUnit import rvPkg::*; (
	input ifIdStage_t ifId,
	input idExStage_t idEx,
	input logic fetchGrant,
	input logic takeBranch,
	output logic pcEn,
	output logic ifIdEn,
	output logic ifIdClear,
	output logic idExClear
);

	regAddr_t decRs1;
	regAddr_t decRs2;
	logic loadUse;

	// source fields straight from the instruction in decode
	assign decRs1 = ifId.instr[19:15];
	assign decRs2 = ifId.instr[24:20];

	// load in execute whose result decode wants next cycle
	assign loadUse = idEx.memToReg && idEx.rd != '0 &&
		(idEx.rd == decRs1 || idEx.rd == decRs2);

	// enables are active low, high means hold
	// pc always moves on a redirect, else holds on load-use or a refused fetch
	assign pcEn = takeBranch ? 1'b0 : (loadUse | !fetchGrant);

	// decode waits for the load
	assign ifIdEn = loadUse;

	// flush on redirect, bubble when the fetch lost the bus
	// during load-use the held instruction must survive
	assign ifIdClear = takeBranch | (!fetchGrant & !loadUse);

	// bubble into execute for load-use, flush on redirect
	assign idExClear = takeBranch | loadUse;

endmodule

// File: design/pipeRegs.sv
`timescale 1ns/1ps
/* pipeRegs
   IF/ID, ID/EX, EX/MEM and MEM/WB latches with stall and flush */
module pipeRegs import rvPkg::*; (
	input logic clk,
	input logic reset,
	input logic ifIdEn,
	input logic ifIdClear,
	input logic idExClear,
	input ifIdStage_t ifIdIn,
	input idExStage_t idExIn,
	input exMemStage_t exMemIn,
	input memWbStage_t memWbIn,
	output ifIdStage_t ifId,
	output idExStage_t idEx,
	output exMemStage_t exMem,
	output memWbStage_t memWb
);

	// IF/ID
	// clear beats the enable, so a flush also ends a stall
	always_ff @(posedge clk or negedge reset) begin
		if (ifIdClear | !reset) begin
			ifId <= '0;
		end else if (!ifIdEn) begin
			ifId <= ifIdIn;
		end
	end

	// ID/EX
	// an all zero record is a bubble, no write and no memory access
	always_ff @(posedge clk or negedge reset) begin
		if (idExClear | !reset) begin
			idEx <= '0;
		end else begin
			idEx <= idExIn;
		end
	end

	// EX/MEM
	// never stalled, execute always advances
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			exMem <= '0;
		end else begin
			exMem <= exMemIn;
		end
	end

	// MEM/WB
	// loadData arrives here from the bus read
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			memWb <= '0;
		end else begin
			memWb <= memWbIn;
		end
	end

endmodule

// File: design/rvCore.sv
`timescale 1ns/1ps
/* rvCore
   five stage RV32I subset pipeline on one shared memory bus with a retire port */
module rvCore import rvPkg::*; #(
	parameter word_t resetPc = '0
) (
	input logic clk,
	input logic reset,
	input word_t memRdata,
	output word_t memAddr,
	output word_t memWdata,
	output logic memWe,
	output logic retireValid,
	output regAddr_t retireRd,
	output word_t retireData
);

	memReq_t fetchReq;
	memReq_t dataReq;
	logic fetchGrant;
	logic pcEn;
	logic ifIdEn;
	logic ifIdClear;
	logic idExClear;
	logic takeBranch;
	word_t target;
	word_t fetchPc;
	word_t fetchInstr;
	word_t wbData;
	ifIdStage_t ifIdIn;
	ifIdStage_t ifId;
	idExStage_t idExIn;
	idExStage_t idEx;
	exMemStage_t exMemIn;
	exMemStage_t exMem;
	memWbStage_t memWbIn;
	memWbStage_t memWb;

	fetchUnit #(
		.resetPc(resetPc)
	) fetch (
		.clk(clk),
		.reset(reset),
		.pcEn(pcEn),
		.takeBranch(takeBranch),
		.target(target),
		.memRdata(memRdata),
		.fetchReq(fetchReq),
		.fetchPc(fetchPc),
		.fetchInstr(fetchInstr)
	);

	assign ifIdIn.instr = fetchInstr;
	assign ifIdIn.pc = fetchPc;

	// data access request from the memory stage
	assign dataReq.addr = exMem.aluOut;
	assign dataReq.wdata = exMem.storeData;
	assign dataReq.write = exMem.memWrite;
	assign dataReq.valid = exMem.memWrite | exMem.memToReg;

	memArbiter arb (
		.fetchReq(fetchReq),
		.dataReq(dataReq),
		.fetchGrant(fetchGrant),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWe(memWe)
	);

	decodeUnit decode (
		.clk(clk),
		.reset(reset),
		.ifId(ifId),
		.wbWe(memWb.regWrite),
		.wbRd(memWb.rd),
		.wbData(wbData),
		.idOut(idExIn)
	);

	execUnit exec (
		.idEx(idEx),
		.exMem(exMem),
		.memWb(memWb),
		.exOut(exMemIn),
		.takeBranch(takeBranch),
		.target(target)
	);

	hazardUnit hazard (
		.ifId(ifId),
		.idEx(idEx),
		.fetchGrant(fetchGrant),
		.takeBranch(takeBranch),
		.pcEn(pcEn),
		.ifIdEn(ifIdEn),
		.ifIdClear(ifIdClear),
		.idExClear(idExClear)
	);

	// memory stage result, the bus read is the load data
	assign memWbIn.regWrite = exMem.regWrite;
	assign memWbIn.memToReg = exMem.memToReg;
	assign memWbIn.aluOut = exMem.aluOut;
	assign memWbIn.loadData = memRdata;
	assign memWbIn.rd = exMem.rd;

	pipeRegs regs (
		.clk(clk),
		.reset(reset),
		.ifIdEn(ifIdEn),
		.ifIdClear(ifIdClear),
		.idExClear(idExClear),
		.ifIdIn(ifIdIn),
		.idExIn(idExIn),
		.exMemIn(exMemIn),
		.memWbIn(memWbIn),
		.ifId(ifId),
		.idEx(idEx),
		.exMem(exMem),
		.memWb(memWb)
	);

	// writeback select
	assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluOut;

	// retire only for real register writes, x0 never reported
	assign retireValid = memWb.regWrite & (memWb.rd != '0);
	assign retireRd = memWb.rd;
	assign retireData = wbData;

endmodule

// File: verification/rvCoreTb.sv
`timescale 1ns/1ps
/* rvCoreTb
   runs the program image from the cases file on a bus memory model and checks retires and stores */
module rvCoreTb import rvPkg::*; ;

	localparam int memWords = 1024;
	// first word of the random data region
	localparam int dataBase = 512;
	localparam logic [15:0] lfsrSeed = 16'd29119;
	// list areas inside the case image
	localparam int retireArea = 'h100;
	localparam int storeArea = 'h180;
	localparam word_t endMark = 32'hFFFF_FFFF;

	logic clk;
	logic reset;
	word_t memRdata;
	word_t memAddr;
	word_t memWdata;
	logic memWe;
	logic retireValid;
	regAddr_t retireRd;
	word_t retireData;

	word_t mem [0:memWords-1];
	word_t caseImg [0:511];
	word_t expRd [0:63];
	word_t expVal [0:63];
	word_t expAddr [0:63];
	word_t expData [0:63];
	int numProg = 0;
	int numRetire = 0;
	int numStore = 0;
	int retireIdx = 0;
	int storeIdx = 0;

	rvCore #(
		.resetPc('0)
	) dut (
		.clk(clk),
		.reset(reset),
		.memRdata(memRdata),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWe(memWe),
		.retireValid(retireValid),
		.retireRd(retireRd),
		.retireData(retireData)
	);

	always #5 clk = ~clk;

	// 16 bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// initial content of a data word, replayed from the seed
	function automatic word_t dataWord(input int idx);
		logic [15:0] s;
		word_t w;
		s = lfsrSeed;
		w = '0;
		for (int i = 0; i < (idx - dataBase + 1) * 32; i++) begin
			s = lfsrNext(s);
			w = {w[30:0], s[0]};
		end
		return w;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h got %h", name, expected, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// bus memory model, write then combinational read for the next edge
	always @(negedge clk) begin
		if (memWe) begin
			mem[memAddr[11:2]] = memWdata;
		end
		memRdata <= mem[memAddr[11:2]];
	end

	// retire and store monitor, outputs are settled at the falling edge
	always @(negedge clk) begin
		if (reset && retireValid) begin
			if (retireIdx >= numRetire) begin
				abortRun("unexpected retire after the expected list ended");
			end
			checkEq("retireRd", expRd[retireIdx], 32'(retireRd));
			checkEq("retireData", expVal[retireIdx], retireData);
			retireIdx++;
		end
		if (reset && memWe) begin
			if (storeIdx >= numStore) begin
				abortRun("unexpected store after the expected list ended");
			end
			checkEq("memAddr", expAddr[storeIdx], memAddr);
			checkEq("memWdata", expData[storeIdx], memWdata);
			storeIdx++;
		end
	end

	// watchdog scaled to the program length
	initial begin
		wait (numProg > 0);
		repeat (20 * numProg + 200) @(posedge clk);
		abortRun("program did not finish in time");
	end

	initial begin
		logic [15:0] s;
		word_t w;
		int k;
		clk = 1'b0;
		reset = 1'b0;
		memRdata = '0;
		for (int i = 0; i < 512; i++) begin
			caseImg[i] = endMark;
		end
		$readmemh("rvCoreCases.txt", caseImg);
		// program image from address 0, the rest of the low area stays zero
		for (int i = 0; i < memWords; i++) begin
			mem[i] = '0;
		end
		while (numProg < retireArea && caseImg[numProg] != endMark) begin
			mem[numProg] = caseImg[numProg];
			numProg++;
		end
		// random data region, one LFSR step per bit
		s = lfsrSeed;
		for (int i = dataBase; i < memWords; i++) begin
			w = '0;
			for (int b = 0; b < 32; b++) begin
				s = lfsrNext(s);
				w = {w[30:0], s[0]};
			end
			mem[i] = w;
		end
		// expected retires, bit 8 of rd asks for an initial data word
		k = retireArea;
		while (k < storeArea && caseImg[k] != endMark) begin
			expRd[numRetire] = {27'b0, caseImg[k][4:0]};
			if (caseImg[k][8]) begin
				expVal[numRetire] = dataWord(int'(caseImg[k+1][11:2]));
			end else begin
				expVal[numRetire] = caseImg[k+1];
			end
			numRetire++;
			k += 2;
		end
		k = storeArea;
		while (k < 512 && caseImg[k] != endMark) begin
			expAddr[numStore] = caseImg[k];
			expData[numStore] = caseImg[k+1];
			numStore++;
			k += 2;
		end
		if (numProg == 0) begin
			abortRun("case file holds no program");
		end
		repeat (5) @(negedge clk);
		reset = 1'b1;
		wait (retireIdx == numRetire && storeIdx == numStore);
		// a few more cycles to catch a stray retire or store
		repeat (20) @(negedge clk);
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: rvCore.f
design/rvPkg.sv
design/fetchUnit.sv
design/memArbiter.sv
design/decodeUnit.sv
design/execUnit.sv
design/hazardUnit.sv
design/pipeRegs.sv
design/rvCore.sv
verification/rvCoreTb.sv

// File: rvCoreCases.txt
// @000 program words, @100 retire pairs (rd, value), @180 store pairs (addr, data)
// rd with bit 8 set expects the initial data word at byte address value
@000
05500093 00F00113 002081B3 40118233 // addi x1, addi x2, add x3, sub x4
0021F2B3 0011E333 001343B3 12345437 // and x5, or x6, xor x7, lui x8
67840413 00700013 001004B3 40000513 // addi x8, addi x0, add x9 reads x0, addi x10
00A50533 00852023 00052583 00158633 // base 0x800, sw x8, lw x11, load use add x12
00452683 00068733 00C52423 00752623 // lw x13 random word, use in x14, sw x12, sw x7
00852783 01052803 00F52A23 00208463 // lw x15, lw x16, sw x15, beq not taken
00100893 00209463 00200913 00300993 // addi x17, bne taken, flushed, addi x19
00220463 00400A13 00800AEF 00500B13 // beq taken, flushed, jal x21, flushed
00221463 00600B93 0000006F          // bne not taken, addi x23, park loop
@100
00000001 00000055
00000002 0000000F
00000003 00000064
00000004 0000000F
00000005 00000004
00000006 00000075
00000007 00000020
00000008 12345000
00000008 12345678
00000009 00000055
0000000A 00000400
0000000A 00000800
0000000B 12345678
0000000C 123456CD
0000010D 00000804
0000010E 00000804
0000000F 123456CD
00000110 00000810
00000011 00000001
00000013 00000003
00000015 0000007C
00000017 00000006
@180
00000800 12345678
00000808 123456CD
0000080C 00000020
00000814 123456CD
